// ==== frontend.f ====
hdl/fetch_pkg.sv
hdl/instr_scan.sv
hdl/bht.sv
hdl/ras.sv
hdl/fetch_queue.sv
hdl/pc_gen.sv
hdl/frontend.sv
tb/tb_clock.sv
tb/tb_frontend.sv

// ==== tb/tb_frontend.sv ====
// testbench of the fetch front end, with cache model, reference predictor model and checks
`timescale 1ns/1ps
`default_nettype none

module tb_frontend;
    import fetch_pkg::*;

    localparam int NUM_TESTS = 6;
    localparam logic [63:0] BOOT = 64'h1000;

    logic clk_i, rst_ni;
    logic flush_i, flush_bp_i, set_pc_commit_i, eret_i, ex_valid_i, set_debug_pc_i;
    logic [63:0] boot_addr_i, pc_commit_i, epc_i, trap_vector_base_i;
    resolve_t res;
    icache_req_t ireq;
    icache_rsp_t irsp;
    fetch_entry_t fe;
    logic fe_valid, fe_ready;

    // cache model state
    logic pend_q;
    logic [63:0] pend_addr_q;
    // reference model state
    logic [63:0] exp_pc;
    cf_e exp_cf;
    logic [63:0] m_ra [RAS_DEPTH];
    logic m_rv [RAS_DEPTH];
    logic [1:0] m_cnt [BHT_ENTRIES];
    logic m_bv [BHT_ENTRIES];
    logic [63:0] popped [$];
    int pop_cnt, ret_hits, errors, failed_tests;
    logic held;
    fetch_entry_t held_entry;
    logic [31:0] rng;

    tb_clock u_clock (.clk_o(clk_i), .rst_no(rst_ni));

    frontend dut0 (
        .clk_i(clk_i), .rst_ni(rst_ni), .flush_i(flush_i), .flush_bp_i(flush_bp_i),
        .boot_addr_i(boot_addr_i), .resolved_branch_i(res),
        .set_pc_commit_i(set_pc_commit_i), .pc_commit_i(pc_commit_i), .epc_i(epc_i),
        .eret_i(eret_i), .trap_vector_base_i(trap_vector_base_i), .ex_valid_i(ex_valid_i),
        .set_debug_pc_i(set_debug_pc_i), .icache_req_o(ireq), .icache_rsp_i(irsp),
        .fetch_entry_o(fe), .fetch_entry_valid_o(fe_valid), .fetch_entry_ready_i(fe_ready)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // --------------------
    // memory contents
    // --------------------
    function automatic logic [31:0] enc_branch(input logic [12:0] off);
        return {off[12], off[10:5], 5'd3, 5'd2, 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // word mixes both address halves and takes its kind from the low bits
    function automatic logic [31:0] mem_word(input logic [63:0] addr);
        logic [31:0] r;
        logic [12:0] off;
        r = xorshift(xorshift(32'hd7f3 ^ addr[31:0] ^ {addr[47:32], addr[63:48]}));
        off = 13'(({9'd0, r[11:8]} + 13'd1) << 2);
        case (r[2:0])
            3'd2: return enc_branch(off);
            // backward branches are rare since they loop
            3'd3: return (r[16:14] == 3'd0) ? enc_branch(-off) : {r[31:7], 7'b0010011};
            3'd4: return enc_jal({8'd0, off}, 5'd0);
            3'd5: return enc_jal({8'd0, off}, 5'd1);
            3'd6, 3'd7: return {12'd0, 5'd1, 3'b000, 5'd0, 7'b1100111};
            default: return {r[31:7], 7'b0010011};
        endcase
    endfunction

    // --------------------
    // reference model
    // --------------------
    function automatic void model_push(input logic [63:0] ra);
        for (int i = RAS_DEPTH-1; i > 0; i--) begin
            m_ra[i] = m_ra[i-1];
            m_rv[i] = m_rv[i-1];
        end
        m_ra[0] = ra;
        m_rv[0] = 1'b1;
    endfunction

    // next pc of an entry and the control flow kind it is predicted with
    function automatic logic [63:0] model_next(input logic [63:0] pc, output cf_e kind);
        logic [31:0] w;
        logic [63:0] bimm, jimm, t;
        logic link_rd, taken;
        int idx;
        w = mem_word(pc);
        bimm = {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        jimm = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        link_rd = (w[11:7] == 5'd1) || (w[11:7] == 5'd5);
        idx = int'(pc[5:2]);
        t = pc + 64'd4;
        kind = CF_NONE;
        if (w[6:0] == 7'b1101111) begin
            t = pc + jimm;
            kind = CF_JUMP;
            if (link_rd) model_push(pc + 64'd4);
        end else if (w[6:0] == 7'b1100011) begin
            taken = m_bv[idx] ? m_cnt[idx][1] : bimm[63];
            if (taken) begin
                t = pc + bimm;
                kind = CF_BRANCH;
            end
        end else if (w[6:0] == 7'b1100111) begin
            if ((w[19:15] == 5'd1 || w[19:15] == 5'd5) && w[11:7] == 5'd0 && m_rv[0]) begin
                t = m_ra[0];
                kind = CF_RETURN;
                ret_hits++;
                for (int i = 0; i < RAS_DEPTH-1; i++) begin
                    m_ra[i] = m_ra[i+1];
                    m_rv[i] = m_rv[i+1];
                end
                m_rv[RAS_DEPTH-1] = 1'b0;
            end else begin
                // jalr without a stack prediction falls through
                kind = CF_JUMPR;
                if (link_rd) model_push(pc + 64'd4);
            end
        end
        return t;
    endfunction

    // lowest priority first so the last source that is set wins
    function automatic logic [63:0] redirect_target();
        logic [63:0] t;
        t = exp_pc;
        if (res.valid && res.is_mispredict) t = res.target;
        if (eret_i) t = epc_i;
        if (ex_valid_i) t = trap_vector_base_i;
        if (set_pc_commit_i) t = pc_commit_i + 64'd4;
        if (set_debug_pc_i) t = DM_HALT_ADDR;
        return t;
    endfunction

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // cache answers one cycle after acceptance unless killed
    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pend_q <= 1'b0;
        end else begin
            pend_q      <= ireq.req && irsp.ready && !ireq.kill;
            pend_addr_q <= ireq.vaddr;
        end
    end

    assign irsp.ready = 1'b1;
    assign irsp.valid = pend_q && !ireq.kill;
    assign irsp.vaddr = pend_addr_q;
    assign irsp.data  = mem_word(pend_addr_q);

    // decode side monitor runs the model in pop order
    always @(posedge clk_i) begin
        if (rst_ni) begin
            if (held && fe_valid) begin
                check_val("fetch_entry_o.pc", fe.pc, held_entry.pc);
                check_val("fetch_entry_o.instr", 64'(fe.instr), 64'(held_entry.instr));
                check_val("fetch_entry_o.cf", 64'(fe.cf), 64'(held_entry.cf));
                check_val("fetch_entry_o.predict_target", fe.predict_target,
                          held_entry.predict_target);
            end
            held = fe_valid && !fe_ready && !flush_i;
            held_entry = fe;
            if (fe_valid && fe_ready) begin
                check_val("fetch_entry_o.pc", fe.pc, exp_pc);
                check_val("fetch_entry_o.instr", 64'(fe.instr), 64'(mem_word(fe.pc)));
                popped.push_back(fe.pc);
                pop_cnt++;
                exp_pc = model_next(fe.pc, exp_cf);
                check_val("fetch_entry_o.predict_target", fe.predict_target, exp_pc);
                check_val("fetch_entry_o.cf", 64'(fe.cf), 64'(exp_cf));
            end
            if (flush_i) begin
                exp_pc = redirect_target();
                popped.delete();
            end
            if (flush_bp_i) begin
                for (int i = 0; i < BHT_ENTRIES; i++) m_bv[i] = 1'b0;
                for (int i = 0; i < RAS_DEPTH; i++) m_rv[i] = 1'b0;
            end else if (res.valid && res.is_branch) begin
                if (!m_bv[res.pc[5:2]]) begin
                    m_cnt[res.pc[5:2]] = res.is_taken ? 2'd2 : 2'd1;
                end else if (res.is_taken && m_cnt[res.pc[5:2]] != 2'd3) begin
                    m_cnt[res.pc[5:2]] = m_cnt[res.pc[5:2]] + 2'd1;
                end else if (!res.is_taken && m_cnt[res.pc[5:2]] != 2'd0) begin
                    m_cnt[res.pc[5:2]] = m_cnt[res.pc[5:2]] - 2'd1;
                end
                m_bv[res.pc[5:2]] = 1'b1;
            end
        end
    end

    // --------------------
    // stimulus tasks
    // --------------------
    task automatic wait_pops(input int n);
        int target;
        target = pop_cnt + n;
        while (pop_cnt < target) @(negedge clk_i);
    endtask

    // src bits from high to low are debug, commit, trap, eret and mispredict
    task automatic redirect(input logic [4:0] src);
        flush_i = 1'b1;
        flush_bp_i = 1'b1;
        set_debug_pc_i = src[4];
        set_pc_commit_i = src[3];
        ex_valid_i = src[2];
        eret_i = src[1];
        res = '{valid: src[0], pc: 64'h4000, target: 64'h5000, is_taken: 1'b1,
                is_mispredict: 1'b1, is_branch: 1'b0};
        @(negedge clk_i);
        {flush_i, flush_bp_i, set_debug_pc_i, set_pc_commit_i, ex_valid_i, eret_i} = '0;
        res = '0;
    endtask

    // commit redirect that lands on the given pc
    task automatic jump_to(input logic [63:0] pc);
        pc_commit_i = pc - 64'd4;
        redirect(5'b01000);
    endtask

    function automatic logic [63:0] find_word(input logic [63:0] from, input int kind);
        logic [63:0] a;
        logic [31:0] w;
        a = from;
        forever begin
            w = mem_word(a);
            if (kind == 0 && w[6:0] == 7'b1100011 && !w[31]) return a;
            if (kind == 1 && w[6:0] == 7'b1101111 && w[11:7] == 5'd1) return a;
            a = a + 64'd4;
        end
    endfunction

    task automatic report(input int num, input string name, input int err_start);
        $display("test %0d %s: %0d errors", num, name, errors - err_start);
        if (errors != err_start) failed_tests++;
    endtask

    // watchdog ends the run after 400 cycles per test
    initial begin
        #(NUM_TESTS * 400 * 40);
        $display("watchdog expired before the tests completed");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        logic [63:0] fb_pc;
        logic [31:0] fb_word;
        logic [63:0] fb_imm;
        int e0, h0;
        rng = 32'hd7f3;
        {flush_i, flush_bp_i, set_debug_pc_i, set_pc_commit_i, ex_valid_i, eret_i} = '0;
        boot_addr_i = BOOT;
        pc_commit_i = '0;
        epc_i = 64'h2400;
        trap_vector_base_i = 64'h2800;
        res = '0;
        fe_ready = 1'b1;
        exp_pc = BOOT;
        held = 1'b0;
        {pop_cnt, ret_hits, errors, failed_tests} = '0;
        for (int i = 0; i < RAS_DEPTH; i++) m_rv[i] = 1'b0;
        for (int i = 0; i < BHT_ENTRIES; i++) m_bv[i] = 1'b0;
        @(posedge rst_ni);
        @(negedge clk_i);

        e0 = errors;
        wait_pops(1);
        check_val("fetch_entry_o.pc", popped[0], BOOT);
        wait_pops(19);
        report(1, "boot address", e0);

        e0 = errors;
        wait_pops(60);
        report(2, "static prediction", e0);

        e0 = errors;
        h0 = ret_hits;
        jump_to(find_word(64'h6000, 1));
        wait_pops(40);
        assert (ret_hits > h0) else begin
            $display("no return was predicted from the return stack");
            errors++;
        end
        report(3, "return stack", e0);

        e0 = errors;
        fb_pc = find_word(64'h3000, 0);
        fb_word = mem_word(fb_pc);
        fb_imm = {{52{1'b0}}, fb_word[7], fb_word[30:25], fb_word[11:8], 1'b0};
        jump_to(fb_pc);
        repeat (2) begin
            res = '{valid: 1'b1, pc: fb_pc, target: fb_pc + fb_imm, is_taken: 1'b1,
                    is_mispredict: 1'b0, is_branch: 1'b1};
            @(negedge clk_i);
        end
        res = '0;
        wait_pops(2);
        check_val("fetch_entry_o.pc", popped[1], fb_pc + fb_imm);
        jump_to(fb_pc);
        wait_pops(2);
        check_val("fetch_entry_o.pc", popped[1], fb_pc + 64'd4);
        report(4, "history table", e0);

        e0 = errors;
        pc_commit_i = 64'h2c00;
        redirect(5'b01100);
        wait_pops(1);
        check_val("fetch_entry_o.pc", popped[0], 64'h2c04);
        redirect(5'b11111);
        wait_pops(1);
        check_val("fetch_entry_o.pc", popped[0], DM_HALT_ADDR);
        report(5, "redirect priority", e0);

        e0 = errors;
        fe_ready = 1'b0;
        repeat (12) @(negedge clk_i);
        for (int i = 0; i < 100; i++) begin
            rng = xorshift(rng);
            fe_ready = rng[0];
            @(negedge clk_i);
        end
        fe_ready = 1'b1;
        wait_pops(10);
        report(6, "back-pressure", e0);

        $display("tests %0d, tests failed %0d, checks failed %0d",
                 NUM_TESTS, failed_tests, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end
endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
// testbench clock of 40 ns and active-low reset held for the first two cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk_o,
    output logic rst_no
);
    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;
    end

    // release on a falling edge, in step with the stimulus
    initial begin
        rst_no = 1'b0;
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end
endmodule

`default_nettype wire

// ==== hdl/frontend.sv ====
// top level of the instruction fetch front end, connects pc generation, predictors and queue
`timescale 1ns/1ps
`default_nettype none

module frontend (
    input  wire logic                         clk_i,
    input  wire logic                         rst_ni,
    input  wire logic                         flush_i,
    input  wire logic                         flush_bp_i,
    input  wire logic [fetch_pkg::ADDR_W-1:0] boot_addr_i,
    input  wire fetch_pkg::resolve_t          resolved_branch_i,
    input  wire logic                         set_pc_commit_i,
    input  wire logic [fetch_pkg::ADDR_W-1:0] pc_commit_i,
    input  wire logic [fetch_pkg::ADDR_W-1:0] epc_i,
    input  wire logic                         eret_i,
    input  wire logic [fetch_pkg::ADDR_W-1:0] trap_vector_base_i,
    input  wire logic                         ex_valid_i,
    input  wire logic                         set_debug_pc_i,
    output fetch_pkg::icache_req_t            icache_req_o,
    input  wire fetch_pkg::icache_rsp_t       icache_rsp_i,
    output fetch_pkg::fetch_entry_t           fetch_entry_o,
    output logic                              fetch_entry_valid_o,
    input  wire logic                         fetch_entry_ready_i
);
    import fetch_pkg::*;

    logic [ADDR_W-1:0] bht_pc;
    bht_pred_t         bht_pred;
    ras_entry_t        ras_top;
    logic              ras_push, ras_pop;
    logic [ADDR_W-1:0] ras_data;
    logic              has_room;
    logic              entry_valid;
    fetch_entry_t      entry;

    pc_gen u_pc_gen (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .flush_i            (flush_i),
        .boot_addr_i        (boot_addr_i),
        .resolved_branch_i  (resolved_branch_i),
        .eret_i             (eret_i),
        .epc_i              (epc_i),
        .ex_valid_i         (ex_valid_i),
        .trap_vector_base_i (trap_vector_base_i),
        .set_pc_commit_i    (set_pc_commit_i),
        .pc_commit_i        (pc_commit_i),
        .set_debug_pc_i     (set_debug_pc_i),
        .icache_req_o       (icache_req_o),
        .icache_rsp_i       (icache_rsp_i),
        .bht_pc_o           (bht_pc),
        .bht_pred_i         (bht_pred),
        .ras_top_i          (ras_top),
        .ras_push_o         (ras_push),
        .ras_pop_o          (ras_pop),
        .ras_data_o         (ras_data),
        .has_room_i         (has_room),
        .entry_valid_o      (entry_valid),
        .entry_o            (entry)
    );

    // predictors are cleared only by the dedicated flush
    bht u_bht (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .flush_i  (flush_bp_i),
        .pc_i     (bht_pc),
        .update_i (resolved_branch_i),
        .pred_o   (bht_pred)
    );

    ras u_ras (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (flush_bp_i),
        .push_i  (ras_push),
        .pop_i   (ras_pop),
        .data_i  (ras_data),
        .top_o   (ras_top)
    );

    fetch_queue u_fetch_queue (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .flush_i    (flush_i),
        .push_i     (entry_valid),
        .entry_i    (entry),
        .ready_i    (fetch_entry_ready_i),
        .has_room_o (has_room),
        .valid_o    (fetch_entry_valid_o),
        .entry_o    (fetch_entry_o)
    );

endmodule

`default_nettype wire

// ==== hdl/pc_gen.sv ====
// next-PC generation, response register and branch prediction of the fetch pipeline
`timescale 1ns/1ps
`default_nettype none

module pc_gen (
    input  wire logic                         clk_i,
    input  wire logic                         rst_ni,
    input  wire logic                         flush_i,
    input  wire logic [fetch_pkg::ADDR_W-1:0] boot_addr_i,
    input  wire fetch_pkg::resolve_t          resolved_branch_i,
    input  wire logic                         eret_i,
    input  wire logic [fetch_pkg::ADDR_W-1:0] epc_i,
    input  wire logic                         ex_valid_i,
    input  wire logic [fetch_pkg::ADDR_W-1:0] trap_vector_base_i,
    input  wire logic                         set_pc_commit_i,
    input  wire logic [fetch_pkg::ADDR_W-1:0] pc_commit_i,
    input  wire logic                         set_debug_pc_i,
    output fetch_pkg::icache_req_t            icache_req_o,
    input  wire fetch_pkg::icache_rsp_t       icache_rsp_i,
    output logic [fetch_pkg::ADDR_W-1:0]      bht_pc_o,
    input  wire fetch_pkg::bht_pred_t         bht_pred_i,
    input  wire fetch_pkg::ras_entry_t        ras_top_i,
    output logic                              ras_push_o,
    output logic                              ras_pop_o,
    output logic [fetch_pkg::ADDR_W-1:0]      ras_data_o,
    input  wire logic                         has_room_i,
    output logic                              entry_valid_o,
    output fetch_pkg::fetch_entry_t           entry_o
);
    import fetch_pkg::*;

    // response register
    logic               rsp_valid_q;
    logic [ADDR_W-1:0]  rsp_vaddr_q;
    logic [INSTR_W-1:0] rsp_data_q;
    // scan results
    logic               is_branch, is_jal, is_jalr, is_call, is_return;
    logic [ADDR_W-1:0]  imm;
    // prediction
    logic               bp_valid;
    logic               ras_pop;
    logic [ADDR_W-1:0]  predict_address;
    cf_e                cf;
    // next pc
    logic               rst_load_q;
    logic [ADDR_W-1:0]  npc_q, npc_d;
    logic [ADDR_W-1:0]  fetch_address;
    logic               is_mispredict;
    logic               kill;

    instr_scan u_instr_scan (
        .instr_i     (rsp_data_q),
        .is_branch_o (is_branch),
        .is_jal_o    (is_jal),
        .is_jalr_o   (is_jalr),
        .is_call_o   (is_call),
        .is_return_o (is_return),
        .imm_o       (imm)
    );

    assign bht_pc_o = rsp_vaddr_q;

    // --------------------
    // prediction
    // --------------------
    always_comb begin
        bp_valid        = 1'b0;
        ras_pop         = 1'b0;
        cf              = CF_NONE;
        predict_address = rsp_vaddr_q + 64'd4;
        if (rsp_valid_q) begin
            if (is_jal) begin
                bp_valid = 1'b1;
                cf       = CF_JUMP;
            end else if (is_branch) begin
                // dynamic history first, else backward taken
                bp_valid = bht_pred_i.valid ? bht_pred_i.taken : imm[ADDR_W-1];
                if (bp_valid) cf = CF_BRANCH;
            end else if (is_return && ras_top_i.valid) begin
                bp_valid        = 1'b1;
                ras_pop         = 1'b1;
                cf              = CF_RETURN;
                predict_address = ras_top_i.ra;
            end else if (is_jalr) begin
                // no target buffer, falls through
                cf = CF_JUMPR;
            end
            if (bp_valid && !ras_pop) predict_address = rsp_vaddr_q + imm;
        end
    end

    // a flushed entry never reaches decode, so it leaves the stack alone
    assign ras_push_o = rsp_valid_q && is_call && !flush_i;
    assign ras_pop_o  = ras_pop && !flush_i;
    assign ras_data_o = rsp_vaddr_q + 64'd4;

    assign entry_valid_o = rsp_valid_q;
    assign entry_o       = '{pc: rsp_vaddr_q, instr: rsp_data_q, cf: cf,
                             predict_target: predict_address};

    // --------------------
    // next pc
    // --------------------
    assign is_mispredict = resolved_branch_i.valid && resolved_branch_i.is_mispredict;
    // drop what is in flight on a prediction or any redirect
    assign kill = bp_valid || flush_i || is_mispredict || eret_i || ex_valid_i
                  || set_pc_commit_i || set_debug_pc_i;

    // later assignments win
    always_comb begin
        fetch_address = rst_load_q ? boot_addr_i : npc_q;
        npc_d         = fetch_address;
        if (bp_valid) npc_d = predict_address;
        // sequential only when this request survives
        if (icache_rsp_i.ready && has_room_i && !kill) begin
            npc_d = {fetch_address[ADDR_W-1:2], 2'b00} + 64'd4;
        end
        if (is_mispredict) npc_d = resolved_branch_i.target;
        if (eret_i) npc_d = epc_i;
        if (ex_valid_i) npc_d = trap_vector_base_i;
        if (set_pc_commit_i) npc_d = pc_commit_i + 64'd4;
        if (set_debug_pc_i) npc_d = DM_HALT_ADDR;
    end

    // request only with room for everything in flight
    assign icache_req_o = '{req: has_room_i, kill: kill, vaddr: fetch_address};

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rst_load_q  <= 1'b1;
            npc_q       <= '0;
            rsp_valid_q <= 1'b0;
        end else begin
            rst_load_q  <= 1'b0;
            npc_q       <= npc_d;
            rsp_valid_q <= icache_rsp_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (icache_rsp_i.valid) begin
            rsp_vaddr_q <= icache_rsp_i.vaddr;
            rsp_data_q  <= icache_rsp_i.data;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fetch_queue.sv ====
// circular FIFO of fetch entries towards decode, reports room for the fetches in flight
`timescale 1ns/1ps
`default_nettype none

module fetch_queue (
    input  wire logic                    clk_i,
    input  wire logic                    rst_ni,
    input  wire logic                    flush_i,
    input  wire logic                    push_i,
    input  wire fetch_pkg::fetch_entry_t entry_i,
    input  wire logic                    ready_i,
    output logic                         has_room_o,
    output logic                         valid_o,
    output fetch_pkg::fetch_entry_t      entry_o
);
    import fetch_pkg::*;

    fetch_entry_t                mem_q [FQ_DEPTH];
    logic [$clog2(FQ_DEPTH)-1:0] rd_ptr_q;
    logic [$clog2(FQ_DEPTH)-1:0] wr_ptr_q;
    logic [$clog2(FQ_DEPTH):0]   count_q;
    logic                        do_push;
    logic                        do_pop;

    assign valid_o = (count_q != '0);
    assign entry_o = mem_q[rd_ptr_q];

    assign do_push = push_i && (count_q != FQ_DEPTH[$clog2(FQ_DEPTH):0]);
    assign do_pop  = ready_i && valid_o;

    // two free slots after this cycle's write
    // one for the fetch in the cache and one for a new request
    assign has_room_o = ({1'b0, count_q} + push_i) <= (FQ_DEPTH - 2);

    // --------------------
    // pointers and count
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // storage, entries past the pointers are ignored
    always_ff @(posedge clk_i) begin
        if (do_push && !flush_i) begin
            mem_q[wr_ptr_q] <= entry_i;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/ras.sv ====
// return address stack, pushed by calls and popped by predicted returns
`timescale 1ns/1ps
`default_nettype none

module ras (
    input  wire logic                         clk_i,
    input  wire logic                         rst_ni,
    input  wire logic                         flush_i,
    input  wire logic                         push_i,
    input  wire logic                         pop_i,
    input  wire logic [fetch_pkg::ADDR_W-1:0] data_i,
    output fetch_pkg::ras_entry_t             top_o
);
    import fetch_pkg::*;

    // slot 0 is the top of stack
    ras_entry_t stack_q [RAS_DEPTH];

    assign top_o = stack_q[0];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < RAS_DEPTH; i++) stack_q[i] <= '0;
        end else if (flush_i) begin
            for (int i = 0; i < RAS_DEPTH; i++) stack_q[i] <= '0;
        end else begin
            case ({push_i, pop_i})
                // push shifts down, the oldest falls off the bottom
                2'b10: begin
                    for (int i = RAS_DEPTH-1; i > 0; i--) stack_q[i] <= stack_q[i-1];
                    stack_q[0] <= '{valid: 1'b1, ra: data_i};
                end
                // pop shifts up and empties the bottom slot
                2'b01: begin
                    for (int i = 0; i < RAS_DEPTH-1; i++) stack_q[i] <= stack_q[i+1];
                    stack_q[RAS_DEPTH-1].valid <= 1'b0;
                end
                // both at once replace the top
                2'b11: begin
                    stack_q[0] <= '{valid: 1'b1, ra: data_i};
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/bht.sv ====
// bimodal branch history table of two-bit counters, looked up by fetch pc, trained by resolve
`timescale 1ns/1ps
`default_nettype none

module bht (
    input  wire logic                         clk_i,
    input  wire logic                         rst_ni,
    input  wire logic                         flush_i,
    input  wire logic [fetch_pkg::ADDR_W-1:0] pc_i,
    input  wire fetch_pkg::resolve_t          update_i,
    output fetch_pkg::bht_pred_t              pred_o
);
    import fetch_pkg::*;

    logic [BHT_ENTRIES-1:0]         valid_q;
    logic [1:0]                     cnt_q [BHT_ENTRIES];
    logic [1:0]                     cnt_d;
    logic [$clog2(BHT_ENTRIES)-1:0] rd_idx;
    logic [$clog2(BHT_ENTRIES)-1:0] wr_idx;
    logic                           upd;

    // word-aligned pc bits pick the counter
    assign rd_idx = pc_i[$clog2(BHT_ENTRIES)+1:2];
    assign wr_idx = update_i.pc[$clog2(BHT_ENTRIES)+1:2];
    assign upd    = update_i.valid && update_i.is_branch;

    // lookup, weakly or strongly taken from 2 upward
    assign pred_o.valid = valid_q[rd_idx];
    assign pred_o.taken = cnt_q[rd_idx][1];

    // next counter value
    always_comb begin
        cnt_d = cnt_q[wr_idx];
        if (!valid_q[wr_idx]) begin
            // fresh entry starts weak in the resolved direction
            cnt_d = update_i.is_taken ? 2'd2 : 2'd1;
        end else if (update_i.is_taken) begin
            if (cnt_q[wr_idx] != 2'd3) cnt_d = cnt_q[wr_idx] + 2'd1;
        end else begin
            if (cnt_q[wr_idx] != 2'd0) cnt_d = cnt_q[wr_idx] - 2'd1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else if (upd) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // counters are only meaningful behind a valid bit
    always_ff @(posedge clk_i) begin
        if (upd) begin
            cnt_q[wr_idx] <= cnt_d;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/instr_scan.sv ====
// combinational pre-decode of one fetched word, flags control flow and gives its immediate
`timescale 1ns/1ps
`default_nettype none

module instr_scan (
    input  wire logic [fetch_pkg::INSTR_W-1:0] instr_i,
    output logic                               is_branch_o,
    output logic                               is_jal_o,
    output logic                               is_jalr_o,
    output logic                               is_call_o,
    output logic                               is_return_o,
    output logic [fetch_pkg::ADDR_W-1:0]       imm_o
);
    import fetch_pkg::*;

    logic [6:0]        opcode;
    logic [4:0]        rd;
    logic [4:0]        rs1;
    logic              rd_link;
    logic              rs1_link;
    logic [ADDR_W-1:0] b_imm;
    logic [ADDR_W-1:0] j_imm;

    assign opcode = instr_i[6:0];
    assign rd     = instr_i[11:7];
    assign rs1    = instr_i[19:15];

    // x1 and x5 are the link registers
    assign rd_link  = (rd == 5'd1) || (rd == 5'd5);
    assign rs1_link = (rs1 == 5'd1) || (rs1 == 5'd5);

    assign is_branch_o = (opcode == OPC_BRANCH);
    assign is_jal_o    = (opcode == OPC_JAL);
    assign is_jalr_o   = (opcode == OPC_JALR);

    // call writes a link register, return reads one and discards rd
    assign is_call_o   = (is_jal_o || is_jalr_o) && rd_link;
    assign is_return_o = is_jalr_o && rs1_link && (rd == 5'd0);

    // B-type offset, 13 bits signed
    assign b_imm = {{(ADDR_W-12){instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    // J-type offset, 21 bits signed
    assign j_imm = {{(ADDR_W-20){instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

    assign imm_o = is_jal_o ? j_imm : b_imm;

endmodule

`default_nettype wire

// ==== hdl/fetch_pkg.sv ====
// shared widths, opcodes and structs of the fetch front end, imported by every RTL module
`default_nettype none

package fetch_pkg;

    // --------------------
    // widths and depths
    // --------------------
    localparam int unsigned ADDR_W      = 64;
    localparam int unsigned INSTR_W     = 32;
    localparam int unsigned BHT_ENTRIES = 16;
    localparam int unsigned RAS_DEPTH   = 4;
    localparam int unsigned FQ_DEPTH    = 4;

    // debug entry point
    localparam logic [ADDR_W-1:0] DM_HALT_ADDR = 64'h800;

    // major opcodes of the control flow instructions
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // control flow kind attached to a fetch entry
    typedef enum logic [2:0] {
        CF_NONE   = 3'd0,
        CF_BRANCH = 3'd1,
        CF_JUMP   = 3'd2,
        CF_JUMPR  = 3'd3,
        CF_RETURN = 3'd4
    } cf_e;

    // --------------------
    // cache port
    // --------------------
    typedef struct packed {
        logic              req;
        logic              kill;
        logic [ADDR_W-1:0] vaddr;
    } icache_req_t;

    typedef struct packed {
        logic               ready;
        logic               valid;
        logic [ADDR_W-1:0]  vaddr;
        logic [INSTR_W-1:0] data;
    } icache_rsp_t;

    // --------------------
    // predictors
    // --------------------
    typedef struct packed {
        logic valid;
        logic taken;
    } bht_pred_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] ra;
    } ras_entry_t;

    // branch outcome reported by the back end
    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] pc;
        logic [ADDR_W-1:0] target;
        logic              is_taken;
        logic              is_mispredict;
        logic              is_branch;
    } resolve_t;

    // one instruction on its way to decode
    typedef struct packed {
        logic [ADDR_W-1:0]  pc;
        logic [INSTR_W-1:0] instr;
        cf_e                cf;
        logic [ADDR_W-1:0]  predict_target;
    } fetch_entry_t;

endpackage

`default_nettype wire
